//--- list.f
+incdir+design
design/tcdm_pkg.sv
design/tcdm_rr_mux.sv
design/tcdm_bank.sv
design/tcdm_subsystem.sv
testbench/tcdm_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and exits non-zero unless the run passed.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tcdm_tb -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtcdm_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi

echo "Pass message not found in the simulation output"
exit 1

//--- testbench/tcdm_tb.sv
// Default sizes only (4 channels, 2 banks); a read in the table must follow a write to the same row.
`timescale 1ns/1ps
`include "tcdm_defines.svh"

module tcdm_tb;

  localparam int NI = `TCDM_NB_IN_CHAN;
  localparam int NO = `TCDM_NB_OUT_CHAN;
  localparam int G  = NI / NO;
  localparam int AW = `TCDM_AW;
  localparam int DW = `TCDM_DW;
  localparam int BW = `TCDM_BANK_WORDS;

  // One table row holds new requests with their fields, the bank stalls and a clear pulse.
  typedef struct packed {
    logic [NI-1:0]           req;
    logic [NI-1:0]           wen;
    logic [NI-1:0][DW/8-1:0] be;
    logic [NI-1:0][AW-1:0]   add;
    logic [NI-1:0][DW-1:0]   data;
    logic [NO-1:0]           stall;
    logic                    clr;
  } row_t;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       clear_i;
  logic [NI-1:0]              in_req;
  tcdm_pkg::addr_u [NI-1:0]   in_add;
  logic [NI-1:0]              in_wen;
  tcdm_pkg::strb_t [NI-1:0]   in_be;
  tcdm_pkg::data_t [NI-1:0]   in_data;
  logic [NI-1:0]              in_gnt;
  tcdm_pkg::data_t [NI-1:0]   in_r_data;
  logic [NI-1:0]              in_r_valid;
  logic [NO-1:0]              bank_stall;

  // Stimulus table and its state.
  row_t        tbl [$];
  logic        tbl_done = 1'b0;
  logic [31:0] rng;
  int          errs;
  int          n_checks;

  // Reference model: pending request per channel, rr counter, shadow banks, next responses.
  logic [NI-1:0]           pend;
  logic [NI-1:0]           p_wen;
  logic [NI-1:0][DW/8-1:0] p_be;
  logic [NI-1:0][AW-1:0]   p_add;
  logic [NI-1:0][DW-1:0]   p_data;
  int                      rr;
  int                      wait_cnt [NI];
  tcdm_pkg::data_t         shadow [NO][BW];
  logic [NI-1:0]           exp_rv;
  logic [NI-1:0]           exp_rd;
  tcdm_pkg::data_t         exp_data [NI];

  tcdm_subsystem tcdm_subsystem_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .in_req     (in_req),
    .in_add     (in_add),
    .in_wen     (in_wen),
    .in_be      (in_be),
    .in_data    (in_data),
    .in_gnt     (in_gnt),
    .in_r_data  (in_r_data),
    .in_r_valid (in_r_valid),
    .bank_stall (bank_stall)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_val(input string what, input logic [DW-1:0] got,
                           input logic [DW-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      errs++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Channel c addresses row rbase + c/NO in its bank, so group members never collide.
  task automatic push_row(input logic [NI-1:0] req, input logic [NI-1:0] wen,
                          input logic [DW/8-1:0] be, input int rbase,
                          input logic [NO-1:0] stall, input logic clr);
    row_t r;
    r.req   = req;
    r.wen   = wen;
    r.stall = stall;
    r.clr   = clr;
    for (int c = 0; c < NI; c++) begin
      rng       = xorshift32(rng);
      r.be[c]   = be;
      r.add[c]  = AW'((rbase + c / NO) * 4);
      r.data[c] = rng;
    end
    tbl.push_back(r);
  endtask

  task automatic build_table();
    // Idle start, then a write and read-back on channel 0 and on channel 3.
    push_row('0, '0, 4'hF, 0, '0, 1'b0);
    push_row('0, '0, 4'hF, 0, '0, 1'b0);
    push_row(4'b0001, 4'b0000, 4'hF, 5, '0, 1'b0);
    push_row(4'b0001, 4'b0001, 4'hF, 5, '0, 1'b0);
    push_row(4'b1000, 4'b0000, 4'hF, 7, '0, 1'b0);
    push_row(4'b1000, 4'b1000, 4'hF, 7, '0, 1'b0);
    push_row('0, '0, 4'hF, 0, '0, 1'b0);
    // All channels contend, first with writes and then with reads.
    push_row('1, '0, 4'hF, 20, '0, 1'b0);
    for (int n = 0; n < 5; n++) begin
      push_row('1, '1, 4'hF, 20, '0, 1'b0);
    end
    // Let the last reads drain so that channel 1 starts the next part with nothing pending.
    push_row('0, '0, 4'hF, 0, '0, 1'b0);
    // Partial byte enables on channel 1 merge into one word.
    push_row(4'b0010, 4'b0000, 4'hF, 9, '0, 1'b0);
    push_row(4'b0010, 4'b0000, 4'b0101, 9, '0, 1'b0);
    push_row(4'b0010, 4'b0000, 4'b1000, 9, '0, 1'b0);
    push_row(4'b0010, 4'b0010, 4'hF, 9, '0, 1'b0);
    // Bank 0 stalled while bank 1 keeps serving, then released.
    // The last stalled row finds bank 1 with nothing to do, so rr must hold.
    push_row('1, '0, 4'hF, 30, 2'b01, 1'b0);
    for (int n = 0; n < 2; n++) begin
      push_row(4'b0101, '0, 4'hF, 30, 2'b01, 1'b0);
    end
    for (int n = 0; n < 5; n++) begin
      push_row('1, '1, 4'hF, 30, '0, 1'b0);
    end
    // A clear pulse under contention and another one with no new requests.
    push_row('1, '0, 4'hF, 40, '0, 1'b0);
    push_row('1, '0, 4'hF, 40, '0, 1'b1);
    for (int n = 0; n < 4; n++) begin
      push_row('1, '1, 4'hF, 40, '0, 1'b0);
    end
    push_row('0, '0, 4'hF, 0, '0, 1'b1);
    push_row('1, '0, 4'hF, 44, '0, 1'b0);
    push_row('1, '1, 4'hF, 44, '0, 1'b0);
    // Drain whatever is still pending.
    for (int n = 0; n < 4; n++) begin
      push_row('0, '0, 4'hF, 0, '0, 1'b0);
    end
  endtask

  // Drives one row, checks the DUT mid-cycle and advances the model to the next cycle.
  task automatic step_row(input row_t r);
    int              win [NO];
    int              k;
    int              ch;
    int              row;
    logic            any;
    logic            any_g;
    logic [NI-1:0]   exp_gnt;
    logic [NI-1:0]   nxt_rv;
    logic [NI-1:0]   nxt_rd;
    tcdm_pkg::data_t nxt_data [NI];
    // A channel still waiting for its grant keeps its old request and ignores the row.
    for (int c = 0; c < NI; c++) begin
      if (!pend[c] && r.req[c]) begin
        pend[c]   = 1'b1;
        p_wen[c]  = r.wen[c];
        p_be[c]   = r.be[c];
        p_add[c]  = r.add[c];
        p_data[c] = r.data[c];
      end
    end
    in_req     = pend;
    in_add     = p_add;
    in_wen     = p_wen;
    in_be      = p_be;
    in_data    = p_data;
    bank_stall = r.stall;
    clear_i    = r.clr;
    #2;
    // Expected winner per port from the rotating scan.
    any     = 1'b0;
    exp_gnt = '0;
    for (int i = 0; i < NO; i++) begin
      win[i] = -1;
      for (int n = 0; n < G; n++) begin
        k  = (rr + i + n) % G;
        ch = k * NO + i;
        if (win[i] < 0 && pend[ch] && !r.stall[i]) begin
          win[i] = ch;
        end
      end
      if (win[i] >= 0) begin
        exp_gnt[win[i]] = 1'b1;
      end
    end
    check_val("in_gnt", DW'(in_gnt), DW'(exp_gnt));
    check_val("in_r_valid", DW'(in_r_valid), DW'(exp_rv));
    for (int c = 0; c < NI; c++) begin
      if (exp_rv[c] && exp_rd[c]) begin
        check_val($sformatf("in_r_data[%0d]", c), in_r_data[c], exp_data[c]);
      end
    end
    // Fairness is judged on the grants the DUT actually gave.
    // A stalled group or a clear restarts the count.
    for (int i = 0; i < NO; i++) begin
      any_g = 1'b0;
      for (int m = 0; m < G; m++) begin
        any_g = any_g | in_gnt[m*NO+i];
      end
      for (int m = 0; m < G; m++) begin
        ch = m * NO + i;
        if (in_gnt[ch] || r.stall[i] || r.clr) begin
          wait_cnt[ch] = 0;
        end else if (any_g && pend[ch]) begin
          wait_cnt[ch]++;
        end
      end
    end
    nxt_rv = '0;
    nxt_rd = '0;
    for (int c = 0; c < NI; c++) begin
      nxt_data[c] = '0;
    end
    for (int i = 0; i < NO; i++) begin
      if (win[i] >= 0) begin
        ch         = win[i];
        any        = 1'b1;
        row        = (int'(p_add[ch]) / 4) % BW;
        nxt_rv[ch] = 1'b1;
        if (p_wen[ch]) begin
          nxt_rd[ch]   = 1'b1;
          nxt_data[ch] = shadow[i][row];
        end else begin
          for (int b = 0; b < DW / 8; b++) begin
            if (p_be[ch][b]) begin
              shadow[i][row][8*b+:8] = p_data[ch][8*b+:8];
            end
          end
        end
        pend[ch] = 1'b0;
      end
    end
    if (r.clr) begin
      rr = 0;
    end else if (any) begin
      rr = (rr + 1) % G;
    end
    exp_rv = nxt_rv;
    exp_rd = nxt_rd;
    for (int c = 0; c < NI; c++) begin
      exp_data[c] = nxt_data[c];
      check_val($sformatf("channel %0d served within %0d transfers", c, G),
                DW'(wait_cnt[c] < G), DW'(1));
    end
  endtask

  initial begin
    rng        = 32'h45cf_a791;
    errs       = 0;
    n_checks   = 0;
    rr         = 0;
    pend       = '0;
    p_wen      = '0;
    p_be       = '0;
    p_add      = '0;
    p_data     = '0;
    exp_rv     = '0;
    exp_rd     = '0;
    rst_ni     = 1'b0;
    clear_i    = 1'b0;
    in_req     = '0;
    in_add     = '0;
    in_wen     = '0;
    in_be      = '0;
    in_data    = '0;
    bank_stall = '0;
    for (int c = 0; c < NI; c++) begin
      wait_cnt[c] = 0;
      exp_data[c] = '0;
    end
    build_table();
    tbl_done = 1'b1;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #2;
    check_val("in_gnt after reset", DW'(in_gnt), '0);
    check_val("in_r_valid after reset", DW'(in_r_valid), '0);
    foreach (tbl[r]) begin
      @(negedge clk_i);
      step_row(tbl[r]);
    end
    $display("Finished %0d rows: %0d checks, %0d errors", tbl.size(), n_checks, errs);
    if (errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Each row gets 20 cycles, which leaves a wide margin over the single cycle it needs.
  initial begin
    wait (tbl_done);
    repeat (tbl.size() * 20 + 10) @(posedge clk_i);
    $display("Watchdog expired before the stimulus table was finished");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- design/tcdm_subsystem.sv
// Channel j always lands on bank j mod NB_OUT_CHAN, and the address only selects a row there.
`timescale 1ns/1ps
`include "tcdm_defines.svh"

module tcdm_subsystem #(
  parameter int NB_IN_CHAN  = `TCDM_NB_IN_CHAN,
  parameter int NB_OUT_CHAN = `TCDM_NB_OUT_CHAN
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                clear_i,
  input  logic             [NB_IN_CHAN-1:0]   in_req,
  input  tcdm_pkg::addr_u  [NB_IN_CHAN-1:0]   in_add,
  input  logic             [NB_IN_CHAN-1:0]   in_wen,
  input  tcdm_pkg::strb_t  [NB_IN_CHAN-1:0]   in_be,
  input  tcdm_pkg::data_t  [NB_IN_CHAN-1:0]   in_data,
  output logic             [NB_IN_CHAN-1:0]   in_gnt,
  output tcdm_pkg::data_t  [NB_IN_CHAN-1:0]   in_r_data,
  output logic             [NB_IN_CHAN-1:0]   in_r_valid,
  input  logic             [NB_OUT_CHAN-1:0]  bank_stall
);

  // Memory port bundle between the multiplexer and the banks.
  logic            [NB_OUT_CHAN-1:0] mem_req;
  tcdm_pkg::addr_u [NB_OUT_CHAN-1:0] mem_add;
  logic            [NB_OUT_CHAN-1:0] mem_wen;
  tcdm_pkg::strb_t [NB_OUT_CHAN-1:0] mem_be;
  tcdm_pkg::data_t [NB_OUT_CHAN-1:0] mem_data;
  logic            [NB_OUT_CHAN-1:0] mem_gnt;
  tcdm_pkg::data_t [NB_OUT_CHAN-1:0] mem_r_data;
  logic            [NB_OUT_CHAN-1:0] mem_r_valid;

  tcdm_rr_mux #(
    .NB_IN_CHAN  (NB_IN_CHAN),
    .NB_OUT_CHAN (NB_OUT_CHAN)
  ) i_mux (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .in_req      (in_req),
    .in_add      (in_add),
    .in_wen      (in_wen),
    .in_be       (in_be),
    .in_data     (in_data),
    .in_gnt      (in_gnt),
    .in_r_data   (in_r_data),
    .in_r_valid  (in_r_valid),
    .mem_req     (mem_req),
    .mem_add     (mem_add),
    .mem_wen     (mem_wen),
    .mem_be      (mem_be),
    .mem_data    (mem_data),
    .mem_gnt     (mem_gnt),
    .mem_r_data  (mem_r_data),
    .mem_r_valid (mem_r_valid)
  );

  // One bank behind each memory port, each with its own stall input.
  for (genvar i = 0; i < NB_OUT_CHAN; i++) begin : gen_bank
    tcdm_bank i_bank (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .stall   (bank_stall[i]),
      .req     (mem_req[i]),
      .wen     (mem_wen[i]),
      .add     (mem_add[i]),
      .be      (mem_be[i]),
      .data    (mem_data[i]),
      .gnt     (mem_gnt[i]),
      .r_data  (mem_r_data[i]),
      .r_valid (mem_r_valid[i])
    );
  end

endmodule

//--- design/tcdm_bank.sv
// Single-ported bank with a fixed one-cycle response; only the row field of the address is decoded.
`timescale 1ns/1ps
`include "tcdm_defines.svh"

module tcdm_bank (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             stall,
  input  logic             req,
  input  logic             wen,
  input  tcdm_pkg::addr_u  add,
  input  tcdm_pkg::strb_t  be,
  input  tcdm_pkg::data_t  data,
  output logic             gnt,
  output tcdm_pkg::data_t  r_data,
  output logic             r_valid
);

  // Storage array, one entry per row.
  tcdm_pkg::data_t mem_q [`TCDM_BANK_WORDS];

  // Row addressed by the current request.
  logic [`TCDM_ROW_W-1:0] row;

  // High in a cycle where a request is accepted.
  logic xfer;

  // Read word and response strobe for the cycle after the grant.
  tcdm_pkg::data_t r_data_q;
  logic            r_valid_q;

  // The bank is always ready unless held off from outside.
  assign gnt  = ~stall;
  assign xfer = req & gnt;
  assign row  = add.f.row;

  // Writes merge only the enabled bytes into the addressed word.
  // A read captures the whole word, and writes leave the last read data in place.
  always_ff @(posedge clk_i) begin
    if (xfer && !wen) begin
      for (int b = 0; b < `TCDM_DW / 8; b++) begin
        if (be[b]) begin
          mem_q[row][8*b+:8] <= data[8*b+:8];
        end
      end
    end
    if (xfer && wen) begin
      r_data_q <= mem_q[row];
    end
  end

  // Every accepted request, read or write, gets one response strobe.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= xfer;
    end
  end

  assign r_data  = r_data_q;
  assign r_valid = r_valid_q;

  // The response strobe follows a granted request by exactly one cycle.
  assert property (@(posedge clk_i) disable iff (!rst_ni) r_valid |-> $past(req && gnt))
    else $error("r_valid without a granted request in the previous cycle");

endmodule

//--- design/tcdm_rr_mux.sv
// Static port grouping (channel j to port j mod NB_OUT_CHAN), one shared rr counter, one-cycle memories only.
`timescale 1ns/1ps
`include "tcdm_defines.svh"

module tcdm_rr_mux #(
  parameter int NB_IN_CHAN  = `TCDM_NB_IN_CHAN,
  parameter int NB_OUT_CHAN = `TCDM_NB_OUT_CHAN
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  clear_i,
  input  logic               [NB_IN_CHAN-1:0]   in_req,
  input  tcdm_pkg::addr_u    [NB_IN_CHAN-1:0]   in_add,
  input  logic               [NB_IN_CHAN-1:0]   in_wen,
  input  tcdm_pkg::strb_t    [NB_IN_CHAN-1:0]   in_be,
  input  tcdm_pkg::data_t    [NB_IN_CHAN-1:0]   in_data,
  output logic               [NB_IN_CHAN-1:0]   in_gnt,
  output tcdm_pkg::data_t    [NB_IN_CHAN-1:0]   in_r_data,
  output logic               [NB_IN_CHAN-1:0]   in_r_valid,
  output logic               [NB_OUT_CHAN-1:0]  mem_req,
  output tcdm_pkg::addr_u    [NB_OUT_CHAN-1:0]  mem_add,
  output logic               [NB_OUT_CHAN-1:0]  mem_wen,
  output tcdm_pkg::strb_t    [NB_OUT_CHAN-1:0]  mem_be,
  output tcdm_pkg::data_t    [NB_OUT_CHAN-1:0]  mem_data,
  input  logic               [NB_OUT_CHAN-1:0]  mem_gnt,
  input  tcdm_pkg::data_t    [NB_OUT_CHAN-1:0]  mem_r_data,
  input  logic               [NB_OUT_CHAN-1:0]  mem_r_valid
);

  // Members per group and the width needed to index one of them.
  localparam int G  = NB_IN_CHAN / NB_OUT_CHAN;
  localparam int GW = (G > 1) ? $clog2(G) : 1;

  // Shared round-robin counter, always in the range 0 to G-1.
  logic [GW-1:0] rr_q;

  // Winning group member per port, for this cycle and the previous one.
  logic [NB_OUT_CHAN-1:0][GW-1:0] winner_d;
  logic [NB_OUT_CHAN-1:0][GW-1:0] winner_q;

  // A port transfers when its forwarded request meets the bank grant.
  logic [NB_OUT_CHAN-1:0] xfer;
  logic [NB_OUT_CHAN-1:0] xfer_q;

  // Grants regrouped per port, only looked at by the checks below.
  logic [NB_OUT_CHAN-1:0][G-1:0] grp_gnt;

  assign xfer = mem_req & mem_gnt;

  // The counter moves on whenever any port completed a transfer.
  // A stalled group therefore still sees its priority rotate.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (clear_i) begin
      rr_q <= '0;
    end else if (|xfer) begin
      if (rr_q == GW'(G - 1)) begin
        rr_q <= '0;
      end else begin
        rr_q <= rr_q + 1'b1;
      end
    end
  end

  // Rotating priority scan.
  // Port i looks at members (rr + i + n) mod G in order and keeps the first requester.
  // With no requester the first candidate stays selected, and mem_req is then low anyway.
  always_comb begin : arbiter
    int   k;
    logic found;
    k     = 0;
    found = 1'b0;
    for (int i = 0; i < NB_OUT_CHAN; i++) begin
      found       = 1'b0;
      winner_d[i] = GW'((int'(rr_q) + i) % G);
      for (int n = 0; n < G; n++) begin
        k = (int'(rr_q) + i + n) % G;
        if (!found && in_req[k*NB_OUT_CHAN+i]) begin
          found       = 1'b1;
          winner_d[i] = GW'(k);
        end
      end
    end
  end

  for (genvar i = 0; i < NB_OUT_CHAN; i++) begin : gen_port
    // Request side is purely combinational from the winner's fields.
    assign mem_req[i]     = in_req[winner_d[i]*NB_OUT_CHAN+i];
    assign mem_add[i].raw = in_add[winner_d[i]*NB_OUT_CHAN+i].raw;
    assign mem_wen[i]     = in_wen[winner_d[i]*NB_OUT_CHAN+i];
    assign mem_be[i]      = in_be[winner_d[i]*NB_OUT_CHAN+i];
    assign mem_data[i]    = in_data[winner_d[i]*NB_OUT_CHAN+i];

    for (genvar k = 0; k < G; k++) begin : gen_member
      assign grp_gnt[i][k] = in_gnt[k*NB_OUT_CHAN+i];
    end

    // Remember who was served, since the bank answers one cycle later.
    // clear_i leaves this alone so that a response in flight still reaches its channel.
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        winner_q[i] <= '0;
        xfer_q[i]   <= 1'b0;
      end else begin
        winner_q[i] <= winner_d[i];
        xfer_q[i]   <= xfer[i];
      end
    end

    // Only the winner of each port may ever hold a grant.
    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(grp_gnt[i]))
      else $error("more than one grant in the group of port %0d", i);
  end

  // Grants go to this cycle's winners, responses to last cycle's winners.
  // Every other channel sees zero data and no valid.
  always_comb begin
    for (int j = 0; j < NB_IN_CHAN; j++) begin
      in_gnt[j]     = 1'b0;
      in_r_data[j]  = '0;
      in_r_valid[j] = 1'b0;
    end
    for (int i = 0; i < NB_OUT_CHAN; i++) begin
      in_gnt[winner_d[i]*NB_OUT_CHAN+i]     = xfer[i];
      in_r_data[winner_q[i]*NB_OUT_CHAN+i]  = mem_r_data[i];
      in_r_valid[winner_q[i]*NB_OUT_CHAN+i] = mem_r_valid[i] & xfer_q[i];
    end
  end

  // A grant never reaches a channel that is not asking.
  assert property (@(posedge clk_i) disable iff (!rst_ni) (in_gnt & ~in_req) == '0)
    else $error("grant without request, gnt %b req %b", in_gnt, in_req);

endmodule

//--- design/tcdm_pkg.sv
// Shared word and address types; the address layout assumes 4-byte words and a power-of-two bank.
`include "tcdm_defines.svh"

package tcdm_pkg;

  // One data word as carried on every channel and memory port.
  typedef logic [`TCDM_DW-1:0] data_t;

  // Byte enables, one bit per byte of data_t.
  typedef logic [`TCDM_DW/8-1:0] strb_t;

  // Field view of a byte address.
  // The upper part is ignored by the banks, so addresses above one bank alias.
  typedef struct packed {
    logic [`TCDM_AW-`TCDM_ROW_W-3:0] unused;
    logic [`TCDM_ROW_W-1:0]          row;
    logic [1:0]                      offs;
  } addr_fields_t;

  // The multiplexer passes the raw address on untouched.
  // The bank reads the same bits through the field view to find its row.
  typedef union packed {
    logic [`TCDM_AW-1:0] raw;
    addr_fields_t        f;
  } addr_u;

endpackage

//--- design/tcdm_defines.svh
// Subsystem sizes: TCDM_NB_IN_CHAN must be a multiple of TCDM_NB_OUT_CHAN and TCDM_DW must stay 32.
`ifndef TCDM_DEFINES_SVH
`define TCDM_DEFINES_SVH

// Number of virtual load/store channels entering the multiplexer.
`define TCDM_NB_IN_CHAN 4

// Number of memory ports, which is also the number of banks.
`define TCDM_NB_OUT_CHAN 2

// Data word width in bits.
// The byte offset field of the address is two bits wide, so 32 is the only width that fits.
`define TCDM_DW 32

// Byte address width seen by every channel.
`define TCDM_AW 16

// Depth of each bank in words, a power of two.
`define TCDM_BANK_WORDS 64

// Width of the row index that selects a word inside one bank.
`define TCDM_ROW_W $clog2(`TCDM_BANK_WORDS)

`endif
